// ==== rvd_macros.svh ====
`ifndef RVD_MACROS_SVH
`define RVD_MACROS_SVH

// Width of data words, PCs and register contents.
`define RVD_XLEN 32

// RV32E has sixteen integer registers.
`define RVD_NREGS 16

// Default number of entries in each queue.
`define RVD_QUEUE_DEPTH 2

`endif

// ==== rvd_pkg.sv ====
`default_nettype none

`include "rvd_macros.svh"

package rvd_pkg;

  localparam int REG_AW = $clog2(`RVD_NREGS);

  // ########################################
  // Opcodes
  // ########################################
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_FENCE  = 7'b0001111;

  // Encoded as {funct7[5], funct3}, so OP and OP-IMM map straight across.
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_t;

  // ########################################
  // Payloads
  // ########################################
  typedef struct packed {
    logic [`RVD_XLEN-1:0] pc;
    logic [31:0]          inst;
  } fetch_pkt_t;

  typedef struct packed {
    logic                 valid;
    logic [REG_AW-1:0]    idx;
    logic [`RVD_XLEN-1:0] data;
  } wb_t;

  typedef struct packed {
    logic [`RVD_XLEN-1:0] pc;
    alu_op_t              alu_op;
    logic [`RVD_XLEN-1:0] op1;
    logic [`RVD_XLEN-1:0] op2;
    logic [`RVD_XLEN-1:0] imm;
    logic [REG_AW-1:0]    rd;
    logic                 rd_we;
    logic                 mem_ren;
    logic                 mem_wen;
    logic [`RVD_XLEN-1:0] mem_addr;
    logic                 jump_en;
    logic [`RVD_XLEN-1:0] jump_base;
    logic                 illegal;
  } decode_op_t;

endpackage

`default_nettype wire

// ==== rvd_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvd_macros.svh"

module rvd_queue #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = `RVD_QUEUE_DEPTH
) (
  input  wire      clk,
  input  wire      rst,
  input  wire      in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  wire      out_ready_i,
  output payload_t out_data_o
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  payload_t mem_q [DEPTH];

  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;
  logic          push;
  logic          pop;

  // Pointers wrap at DEPTH, which need not be a power of two.
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
    logic [AW-1:0] nxt;
    nxt = (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  assign in_ready_o  = (count_q != CW'(DEPTH));
  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rvd_regfile_scoreboard.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvd_macros.svh"

module rvd_regfile_scoreboard
  import rvd_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst,
  input  wire  [REG_AW-1:0]     raddr1_i,
  input  wire  [REG_AW-1:0]     raddr2_i,
  output logic [`RVD_XLEN-1:0]  rdata1_o,
  output logic [`RVD_XLEN-1:0]  rdata2_o,
  output logic                  busy1_o,
  output logic                  busy2_o,
  input  wb_t                   wb_i,
  input  wire                   set_busy_valid_i,
  input  wire  [REG_AW-1:0]     set_busy_idx_i
);

  logic [`RVD_XLEN-1:0] regs_q [`RVD_NREGS];
  logic [`RVD_NREGS-1:0] busy_q;

  // x0 is hardwired, so both the data and the busy bit read as zero.
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];
  assign busy1_o  = (raddr1_i != '0) & busy_q[raddr1_i];
  assign busy2_o  = (raddr2_i != '0) & busy_q[raddr2_i];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RVD_NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wb_i.valid && wb_i.idx != '0) begin
      regs_q[wb_i.idx] <= wb_i.data;
    end
  end

  // The reservation is applied last, so a new issue to the same register
  // keeps it busy even when an older write retires on the same edge.
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
    end else begin
      if (wb_i.valid && wb_i.idx != '0) begin
        busy_q[wb_i.idx] <= 1'b0;
      end
      if (set_busy_valid_i && set_busy_idx_i != '0) begin
        busy_q[set_busy_idx_i] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rvd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvd_macros.svh"

module rvd_decoder
  import rvd_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   in_valid_i,
  output logic                  in_ready_o,
  input  fetch_pkt_t            in_pkt_i,
  output logic [REG_AW-1:0]     raddr1_o,
  output logic [REG_AW-1:0]     raddr2_o,
  input  wire  [`RVD_XLEN-1:0]  rdata1_i,
  input  wire  [`RVD_XLEN-1:0]  rdata2_i,
  input  wire                   busy1_i,
  input  wire                   busy2_i,
  output logic                  set_busy_valid_o,
  output logic [REG_AW-1:0]     set_busy_idx_o,
  output logic                  out_valid_o,
  input  wire                   out_ready_i,
  output decode_op_t            out_op_o
);

  fetch_pkt_t held_q;
  logic       held_valid_q;
  logic       hazard;
  logic       issue;

  logic [31:0]          inst;
  logic [`RVD_XLEN-1:0] pc;
  logic [6:0]           opcode;
  logic [2:0]           funct3;
  logic                 funct7_b5;
  logic [REG_AW-1:0]    rd;

  logic [`RVD_XLEN-1:0] imm_i;
  logic [`RVD_XLEN-1:0] imm_s;
  logic [`RVD_XLEN-1:0] imm_b;
  logic [`RVD_XLEN-1:0] imm_u;
  logic [`RVD_XLEN-1:0] imm_j;

  logic       use_rs1;
  logic       use_rs2;
  logic       writes_rd;
  decode_op_t op;

  // ########################################
  // Holding register and handshake
  // ########################################

  // Busy bits only ever clear while an instruction waits here, so once
  // out_valid_o rises it stays up until the issue queue takes the op.
  assign hazard      = (use_rs1 & busy1_i) | (use_rs2 & busy2_i);
  assign out_valid_o = held_valid_q & ~hazard;
  assign issue       = out_valid_o & out_ready_i;
  assign in_ready_o  = ~held_valid_q | issue;

  always_ff @(posedge clk) begin
    if (rst) begin
      held_valid_q <= 1'b0;
    end else if (in_ready_o) begin
      held_valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      held_q <= in_pkt_i;
    end
  end

  // ########################################
  // Field extraction
  // ########################################
  assign inst      = held_q.inst;
  assign pc        = held_q.pc;
  assign opcode    = inst[6:0];
  assign funct3    = inst[14:12];
  assign funct7_b5 = inst[30];
  assign rd        = inst[7+:REG_AW];

  // RV32E only has 16 registers, so the top index bit is dropped.
  assign raddr1_o = inst[15+:REG_AW];
  assign raddr2_o = inst[20+:REG_AW];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // ########################################
  // Operation build
  // ########################################
  always_comb begin
    op        = '0;
    op.pc     = pc;
    op.alu_op = ALU_ADD;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    writes_rd = 1'b0;
    case (opcode)
      OP_LUI: begin
        op.imm    = imm_u;
        op.op2    = imm_u;
        writes_rd = 1'b1;
      end
      OP_AUIPC: begin
        op.imm    = imm_u;
        op.op1    = pc;
        op.op2    = imm_u;
        writes_rd = 1'b1;
      end
      OP_JAL: begin
        op.imm       = imm_j;
        op.op1       = pc;
        op.op2       = `RVD_XLEN'(4);
        op.jump_en   = 1'b1;
        op.jump_base = pc;
        writes_rd    = 1'b1;
      end
      OP_JALR: begin
        op.imm       = imm_i;
        op.op1       = pc;
        op.op2       = `RVD_XLEN'(4);
        op.jump_en   = 1'b1;
        op.jump_base = rdata1_i;
        use_rs1      = 1'b1;
        writes_rd    = 1'b1;
      end
      OP_BRANCH: begin
        op.imm       = imm_b;
        op.op1       = rdata1_i;
        op.op2       = rdata2_i;
        op.alu_op    = alu_op_t'({1'b0, funct3});
        op.jump_en   = 1'b1;
        op.jump_base = pc;
        use_rs1      = 1'b1;
        use_rs2      = 1'b1;
      end
      OP_LOAD: begin
        op.imm      = imm_i;
        op.op1      = rdata1_i;
        op.op2      = imm_i;
        op.alu_op   = alu_op_t'({1'b0, funct3});
        op.mem_ren  = 1'b1;
        op.mem_addr = rdata1_i + imm_i;
        use_rs1     = 1'b1;
        writes_rd   = 1'b1;
      end
      OP_STORE: begin
        op.imm      = imm_s;
        op.op1      = rdata1_i;
        op.op2      = rdata2_i;
        op.alu_op   = alu_op_t'({1'b0, funct3});
        op.mem_wen  = 1'b1;
        op.mem_addr = rdata1_i + imm_s;
        use_rs1     = 1'b1;
        use_rs2     = 1'b1;
      end
      OP_IMM: begin
        // Only SRAI borrows funct7 bit 5; ADDI never subtracts.
        op.imm    = imm_i;
        op.op1    = rdata1_i;
        op.op2    = imm_i;
        op.alu_op = alu_op_t'({(funct3 == 3'b101) & funct7_b5, funct3});
        use_rs1   = 1'b1;
        writes_rd = 1'b1;
      end
      OP_REG: begin
        op.op1    = rdata1_i;
        op.op2    = rdata2_i;
        op.alu_op = alu_op_t'({funct7_b5, funct3});
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        writes_rd = 1'b1;
      end
      OP_SYSTEM, OP_FENCE: begin
        // Accepted as no-ops at this stage.
      end
      default: begin
        op.illegal = 1'b1;
      end
    endcase
    op.rd_we = writes_rd & (rd != '0);
    op.rd    = op.rd_we ? rd : '0;
  end

  assign out_op_o         = op;
  assign set_busy_valid_o = issue & op.rd_we;
  assign set_busy_idx_o   = rd;

endmodule

`default_nettype wire

// ==== rvd_decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvd_macros.svh"

module rvd_decode_top
  import rvd_pkg::*;
(
  input  wire        clk,
  input  wire        rst,
  input  wire        fetch_valid_i,
  output logic       fetch_ready_o,
  input  fetch_pkt_t fetch_i,
  output logic       op_valid_o,
  input  wire        op_ready_i,
  output decode_op_t op_o,
  input  wb_t        wb_i
);

  fetch_pkt_t fq_pkt;
  logic       fq_valid;
  logic       fq_ready;

  decode_op_t dec_op;
  logic       dec_valid;
  logic       dec_ready;

  logic [REG_AW-1:0]    raddr1;
  logic [REG_AW-1:0]    raddr2;
  logic [`RVD_XLEN-1:0] rdata1;
  logic [`RVD_XLEN-1:0] rdata2;
  logic                 busy1;
  logic                 busy2;
  logic                 set_busy_valid;
  logic [REG_AW-1:0]    set_busy_idx;

  rvd_queue #(
    .payload_t (fetch_pkt_t),
    .DEPTH     (`RVD_QUEUE_DEPTH)
  ) u_fetch_q (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (fetch_valid_i),
    .in_ready_o  (fetch_ready_o),
    .in_data_i   (fetch_i),
    .out_valid_o (fq_valid),
    .out_ready_i (fq_ready),
    .out_data_o  (fq_pkt)
  );

  rvd_decoder u_decoder (
    .clk              (clk),
    .rst              (rst),
    .in_valid_i       (fq_valid),
    .in_ready_o       (fq_ready),
    .in_pkt_i         (fq_pkt),
    .raddr1_o         (raddr1),
    .raddr2_o         (raddr2),
    .rdata1_i         (rdata1),
    .rdata2_i         (rdata2),
    .busy1_i          (busy1),
    .busy2_i          (busy2),
    .set_busy_valid_o (set_busy_valid),
    .set_busy_idx_o   (set_busy_idx),
    .out_valid_o      (dec_valid),
    .out_ready_i      (dec_ready),
    .out_op_o         (dec_op)
  );

  rvd_regfile_scoreboard u_regfile (
    .clk              (clk),
    .rst              (rst),
    .raddr1_i         (raddr1),
    .raddr2_i         (raddr2),
    .rdata1_o         (rdata1),
    .rdata2_o         (rdata2),
    .busy1_o          (busy1),
    .busy2_o          (busy2),
    .wb_i             (wb_i),
    .set_busy_valid_i (set_busy_valid),
    .set_busy_idx_i   (set_busy_idx)
  );

  rvd_queue #(
    .payload_t (decode_op_t),
    .DEPTH     (`RVD_QUEUE_DEPTH)
  ) u_issue_q (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (dec_valid),
    .in_ready_o  (dec_ready),
    .in_data_i   (dec_op),
    .out_valid_o (op_valid_o),
    .out_ready_i (op_ready_i),
    .out_data_o  (op_o)
  );

endmodule

`default_nettype wire

// ==== tb_rvd_decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rvd_decode_top
  import rvd_pkg::*;
();

  localparam int REC_WORDS   = 8;
  localparam int MAX_RECORDS = 128;
  localparam int NUM_TESTS   = 6;
  localparam int CLK_PERIOD  = 40;

  localparam logic [31:0] K_END    = 32'd0;
  localparam logic [31:0] K_TEST   = 32'd1;
  localparam logic [31:0] K_INST   = 32'd2;
  localparam logic [31:0] K_WB     = 32'd3;
  localparam logic [31:0] K_EXPECT = 32'd4;
  localparam logic [31:0] K_WAIT   = 32'd5;
  localparam logic [31:0] K_IDLE   = 32'd6;
  localparam logic [31:0] K_BLOCK  = 32'd7;

  logic       clk;
  logic       rst;
  logic       fetch_valid;
  logic       fetch_ready;
  fetch_pkt_t fetch_pkt;
  logic       op_valid;
  logic       op_ready;
  decode_op_t issued_op;
  wb_t        wb;

  logic [31:0] trace_mem [MAX_RECORDS*REC_WORDS];
  int          rec_test [MAX_RECORDS];
  int          exp_idx_q [$];
  string       test_names [NUM_TESTS];
  int          test_errors [NUM_TESTS];
  integer      seed;
  int          n_records    = 0;
  int          limit        = 0;
  int          cycle_count  = 0;
  int          exp_total    = 0;
  int          received     = 0;
  int          checks       = 0;
  int          mismatches   = 0;
  int          other_errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          block_left   = 0;

  rvd_decode_top DUT (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid),
    .fetch_ready_o (fetch_ready),
    .fetch_i       (fetch_pkt),
    .op_valid_o    (op_valid),
    .op_ready_i    (op_ready),
    .op_o          (issued_op),
    .wb_i          (wb)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ########################################
  // Checking
  // ########################################
  task automatic check_value(input int tid, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("CHECK FAILED test %s, %s: expected %h, actual %h",
               test_names[tid], field, expected, actual);
      mismatches++;
      test_errors[tid]++;
    end
  endtask

  task automatic compare_op(input int rec);
    int          base;
    int          tid;
    logic [31:0] flags;
    base  = rec * REC_WORDS;
    tid   = rec_test[rec];
    flags = trace_mem[base + 7];
    check_value(tid, "pc", trace_mem[base + 1], issued_op.pc);
    check_value(tid, "op1", trace_mem[base + 2], issued_op.op1);
    check_value(tid, "op2", trace_mem[base + 3], issued_op.op2);
    check_value(tid, "imm", trace_mem[base + 4], issued_op.imm);
    check_value(tid, "mem_addr", trace_mem[base + 5], issued_op.mem_addr);
    check_value(tid, "jump_base", trace_mem[base + 6], issued_op.jump_base);
    check_value(tid, "alu_op", flags[3:0], issued_op.alu_op);
    check_value(tid, "rd", flags[7:4], issued_op.rd);
    check_value(tid, "rd_we", flags[8], issued_op.rd_we);
    check_value(tid, "mem_ren", flags[9], issued_op.mem_ren);
    check_value(tid, "mem_wen", flags[10], issued_op.mem_wen);
    check_value(tid, "jump_en", flags[11], issued_op.jump_en);
    check_value(tid, "illegal", flags[12], issued_op.illegal);
  endtask

  // A transfer seen at the falling edge completes on the next rising edge.
  initial begin : monitor
    int idx;
    forever begin
      @(negedge clk);
      if (!rst && op_valid && op_ready) begin
        if (exp_idx_q.size() == 0) begin
          $display("ERROR: an operation with pc %h was issued but none was expected",
                   issued_op.pc);
          other_errors++;
        end else begin
          idx = exp_idx_q.pop_front();
          compare_op(idx);
        end
        received++;
      end
    end
  end

  // Roughly one cycle in three is stalled, unless a hold is in progress.
  initial begin : ready_gen
    int   r;
    logic next_ready;
    forever begin
      @(posedge clk);
      r = $random(seed);
      if (block_left > 0) begin
        block_left--;
        next_ready = 1'b0;
      end else begin
        next_ready = (($unsigned(r) % 3) != 0);
      end
      #2;
      op_ready = next_ready;
    end
  end

  initial begin : watchdog
    wait (limit > 0);
    while (cycle_count < limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("Checks failed");
    $finish;
  end

  // ########################################
  // Driving
  // ########################################
  task automatic load_trace();
    int          r;
    int          tid;
    logic [31:0] kind;
    $readmemh("rvd_trace.txt", trace_mem);
    r   = 0;
    tid = 0;
    while (r < MAX_RECORDS && trace_mem[r*REC_WORDS] != K_END) begin
      kind = trace_mem[r*REC_WORDS];
      if (kind == K_TEST) begin
        tid = trace_mem[r*REC_WORDS + 1];
      end
      rec_test[r] = tid;
      if (kind == K_EXPECT) begin
        exp_idx_q.push_back(r);
      end
      r++;
    end
    n_records = r;
    limit = 20 * n_records + 100;
    if (exp_idx_q.size() == 0) begin
      $display("ERROR: the trace file is missing or holds no expected operations");
      other_errors++;
    end
  endtask

  task automatic send_instruction(input logic [31:0] pc, input logic [31:0] inst);
    logic accepted;
    fetch_pkt.pc   = pc;
    fetch_pkt.inst = inst;
    fetch_valid    = 1'b1;
    accepted       = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = fetch_ready;
      @(posedge clk);
      #2;
    end
    fetch_valid = 1'b0;
  endtask

  task automatic send_writeback(input logic [31:0] idx, input logic [31:0] data);
    wb.valid = 1'b1;
    wb.idx   = idx[REG_AW-1:0];
    wb.data  = data;
    @(posedge clk);
    #2;
    wb.valid = 1'b0;
  endtask

  task automatic wait_issued(input int count);
    while (received < count) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic finish_test(input int tid);
    wait_issued(exp_total);
    if (test_errors[tid] == 0) begin
      $display("test %-14s passed", test_names[tid]);
      tests_passed++;
    end else begin
      $display("test %-14s failed with %0d mismatches", test_names[tid], test_errors[tid]);
      tests_failed++;
    end
  endtask

  initial begin : driver
    int          r;
    int          base;
    int          cur_test;
    logic [31:0] kind;
    seed          = 32'h81e9765c;
    rst           = 1'b1;
    fetch_valid   = 1'b0;
    fetch_pkt     = '0;
    op_ready      = 1'b0;
    wb            = '0;
    test_names[0] = "reset";
    test_names[1] = "alu_decode";
    test_names[2] = "mem_decode";
    test_names[3] = "control_flow";
    test_names[4] = "hazard";
    test_names[5] = "back_pressure";
    load_trace();

    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    check_value(0, "op_valid", 32'd0, op_valid);
    check_value(0, "fetch_ready", 32'd1, fetch_ready);
    @(posedge clk);
    #2;

    cur_test = -1;
    for (r = 0; r < n_records; r++) begin
      base = r * REC_WORDS;
      kind = trace_mem[base];
      case (kind)
        K_TEST: begin
          if (cur_test >= 0) begin
            finish_test(cur_test);
          end
          cur_test = trace_mem[base + 1];
        end
        K_INST:   send_instruction(trace_mem[base + 1], trace_mem[base + 2]);
        K_WB:     send_writeback(trace_mem[base + 1], trace_mem[base + 2]);
        K_EXPECT: exp_total++;
        K_WAIT:   wait_issued(exp_total);
        K_IDLE:   idle_cycles(trace_mem[base + 1]);
        K_BLOCK:  block_left = trace_mem[base + 1];
        default: begin
          $display("ERROR: record %0d has the unknown kind %0d", r, kind);
          other_errors++;
        end
      endcase
    end
    if (cur_test >= 0) begin
      finish_test(cur_test);
    end
    // Any operation arriving now would be a duplicate.
    idle_cycles(10);

    $display("tests passed %0d, tests failed %0d, checks %0d, mismatches %0d, other errors %0d",
             tests_passed, tests_failed, checks, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0 && tests_failed == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rvd_trace.txt ====
// Columns: kind, then seven data words. Kinds: 0 end, 1 test (id), 2 instruction (pc, inst),
// 3 writeback (idx, data), 4 expected op (pc, op1, op2, imm, mem_addr, jump_base, flags),
// 5 wait until issued, 6 idle (cycles), 7 hold op_ready low (cycles).
// flags = {illegal, jump_en, mem_wen, mem_ren, rd_we, rd[3:0], alu_op[3:0]}
1 00000000 00000000 00000000 00000000 00000000 00000000 00000000
2 00000100 00628233 00000000 00000000 00000000 00000000 00000000
4 00000100 00000000 00000000 00000000 00000000 00000000 00000140
1 00000001 00000000 00000000 00000000 00000000 00000000 00000000
3 00000001 00001000 00000000 00000000 00000000 00000000 00000000
3 00000002 00000005 00000000 00000000 00000000 00000000 00000000
3 00000003 fffffff0 00000000 00000000 00000000 00000000 00000000
2 00000200 123453b7 00000000 00000000 00000000 00000000 00000000
4 00000200 00000000 12345000 12345000 00000000 00000000 00000170
2 00000204 00010417 00000000 00000000 00000000 00000000 00000000
4 00000204 00000204 00010000 00010000 00000000 00000000 00000180
2 00000208 4041d513 00000000 00000000 00000000 00000000 00000000
4 00000208 fffffff0 00000404 00000404 00000000 00000000 000001ad
2 0000020c 402085b3 00000000 00000000 00000000 00000000 00000000
4 0000020c 00001000 00000005 00000000 00000000 00000000 000001b8
1 00000002 00000000 00000000 00000000 00000000 00000000 00000000
2 00000300 0080a383 00000000 00000000 00000000 00000000 00000000
4 00000300 00001000 00000008 00000008 00001008 00000000 00000372
2 00000304 fe21ae23 00000000 00000000 00000000 00000000 00000000
4 00000304 fffffff0 00000005 fffffffc ffffffec 00000000 00000402
1 00000003 00000000 00000000 00000000 00000000 00000000 00000000
2 00000400 ff9ff4ef 00000000 00000000 00000000 00000000 00000000
4 00000400 00000400 00000004 fffffff8 00000000 00000400 00000990
2 00000404 00c08567 00000000 00000000 00000000 00000000 00000000
4 00000404 00000404 00000004 0000000c 00000000 00001000 000009a0
2 00000408 02311063 00000000 00000000 00000000 00000000 00000000
4 00000408 00000005 fffffff0 00000020 00000000 00000408 00000801
2 0000040c 0000000b 00000000 00000000 00000000 00000000 00000000
4 0000040c 00000000 00000000 00000000 00000000 00000000 00001000
1 00000004 00000000 00000000 00000000 00000000 00000000 00000000
2 00000500 00100693 00000000 00000000 00000000 00000000 00000000
4 00000500 00000000 00000001 00000001 00000000 00000000 000001d0
5 00000000 00000000 00000000 00000000 00000000 00000000 00000000
2 00000504 00268733 00000000 00000000 00000000 00000000 00000000
4 00000504 0000abcd 00000005 00000000 00000000 00000000 000001e0
2 00000508 0020c7b3 00000000 00000000 00000000 00000000 00000000
4 00000508 00001000 00000005 00000000 00000000 00000000 000001f4
6 00000006 00000000 00000000 00000000 00000000 00000000 00000000
3 0000000d 0000abcd 00000000 00000000 00000000 00000000 00000000
1 00000005 00000000 00000000 00000000 00000000 00000000 00000000
7 0000000c 00000000 00000000 00000000 00000000 00000000 00000000
2 00000600 0f00e393 00000000 00000000 00000000 00000000 00000000
4 00000600 00001000 000000f0 000000f0 00000000 00000000 00000176
2 00000604 7ff1f413 00000000 00000000 00000000 00000000 00000000
4 00000604 fffffff0 000007ff 000007ff 00000000 00000000 00000187
2 00000608 002114b3 00000000 00000000 00000000 00000000 00000000
4 00000608 00000005 00000005 00000000 00000000 00000000 00000191
2 0000060c 0011a533 00000000 00000000 00000000 00000000 00000000
4 0000060c fffffff0 00001000 00000000 00000000 00000000 000001a2
2 00000610 0020d5b3 00000000 00000000 00000000 00000000 00000000
4 00000610 00001000 00000005 00000000 00000000 00000000 000001b5
2 00000614 abcde037 00000000 00000000 00000000 00000000 00000000
4 00000614 00000000 abcde000 abcde000 00000000 00000000 00000000
0 00000000 00000000 00000000 00000000 00000000 00000000 00000000

// ==== compile.f ====
+incdir+.
rvd_pkg.sv
rvd_queue.sv
rvd_regfile_scoreboard.sv
rvd_decoder.sv
rvd_decode_top.sv
tb_rvd_decode_top.sv

// ==== Bender.yml ====
package:
  name: rvd_decode

export_include_dirs:
  - .

sources:
  - files:
      - rvd_pkg.sv
      - rvd_queue.sv
      - rvd_regfile_scoreboard.sv
      - rvd_decoder.sv
      - rvd_decode_top.sv
  - target: test
    files:
      - tb_rvd_decode_top.sv
